// File: logic/icmp_nd_cfg.svh
`ifndef ICMP_ND_CFG_SVH
`define ICMP_ND_CFG_SVH

// Descriptors allowed in flight downstream
`define TX_CREDITS 2

// Duplicate address detection
`define DAD_TRIES      3  // Solicitations per attempt
`define DAD_TIMEOUT_MS 4  // Quiet time after each one

// Echo payload storage
`define ECHO_FIFO_DEPTH 64  // Bytes

// Hop limit carried by ND messages
`define HOP_LIMIT_ND 255

`endif

// File: logic/net_addr_pkg.sv
package net_addr_pkg;

  typedef logic [47:0]  mac_t;  // Ethernet address
  typedef logic [127:0] ip_t;   // IPv6 address
  typedef logic [63:0]  iid_t;  // Interface ID

  localparam logic [63:0]  LLA_PREFIX           = 64'hfe80_0000_0000_0000;
  localparam logic [103:0] SOL_MCAST_PREFIX     = {16'hff02, 64'h0, 16'h0001, 8'hff};
  localparam logic [23:0]  MAC_SOL_MCAST_PREFIX = 24'h3333ff;
  localparam logic [15:0]  EUI64_FILL           = 16'hfffe;

  // EUI-64 layout with U/L bit set, caller picks the low three bytes
  function automatic iid_t form_iid(mac_t mac, logic [23:0] low);
    iid_t iid;
    iid = {mac[47:42], 1'b1, mac[40:24], EUI64_FILL, low};
    return iid;
  endfunction

endpackage

// File: logic/icmp_msg_pkg.sv
package icmp_msg_pkg;

  // ICMPv6 message types handled here
  typedef enum logic [7:0] {
    ICMP_ECHO_REQUEST = 8'd128,
    ICMP_ECHO_REPLY   = 8'd129,
    ICMP_NS           = 8'd135,
    ICMP_NA           = 8'd136
  } icmp_type_t;

  typedef logic [15:0] pld_len_t;  // Echo payload length in bytes
  typedef logic [15:0] cks_t;      // One's-complement checksum

  // Received packet descriptor
  typedef struct packed {
    net_addr_pkg::mac_t src_mac;
    net_addr_pkg::ip_t  src_ip;
    icmp_type_t         typ;
    net_addr_pkg::ip_t  tar;       // ND target
    logic [15:0]        echo_id;
    logic [15:0]        echo_seq;
  } rx_meta_t;

  // Transmit descriptor
  typedef struct packed {
    net_addr_pkg::mac_t dst_mac;
    net_addr_pkg::ip_t  src_ip;
    net_addr_pkg::ip_t  dst_ip;
    icmp_type_t         typ;
    net_addr_pkg::ip_t  tar;
    logic               sol;       // NA solicited flag
    logic               ovr;       // NA override flag
    logic [7:0]         hop;
    logic [15:0]        echo_id;
    logic [15:0]        echo_seq;
    pld_len_t           pld_len;
    cks_t               pld_cks;
  } tx_meta_t;

endpackage

// File: logic/icmp_rx_classify.sv
`timescale 1ns/1ps

module icmp_rx_classify (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rcv,
  input  icmp_msg_pkg::rx_meta_t rx_meta,
  input  net_addr_pkg::ip_t      lla,
  input  logic                   addr_ok,
  output logic                   ns_evt,
  output logic                   na_evt,
  output logic                   echo_evt,
  output icmp_msg_pkg::rx_meta_t evt_meta
);

  import icmp_msg_pkg::*;

  logic tar_hit;
  logic is_ns;
  logic is_na;
  logic is_echo;

  always_comb begin
    tar_hit = (rx_meta.tar == lla);  // Target is our address
    is_ns   = rcv && (rx_meta.typ == ICMP_NS);
    is_na   = rcv && (rx_meta.typ == ICMP_NA);
    is_echo = rcv && (rx_meta.typ == ICMP_ECHO_REQUEST);
  end

  // One-cycle event pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      ns_evt   <= 1'b0;
      na_evt   <= 1'b0;
      echo_evt <= 1'b0;
    end else begin
      ns_evt   <= is_ns && tar_hit && addr_ok;
      na_evt   <= is_na && tar_hit && !addr_ok;  // Conflict during DAD
      echo_evt <= is_echo && addr_ok;
    end
  end

  // Descriptor held until the next packet
  always_ff @(posedge clk) begin
    if (rcv) begin
      evt_meta <= rx_meta;
    end
  end

endmodule

// File: logic/icmp_addr_ctrl.sv
`timescale 1ns/1ps
`include "icmp_nd_cfg.svh"

module icmp_addr_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               tick_ms,
  input  net_addr_pkg::mac_t mac_addr,
  input  logic               na_evt,
  input  logic               dad_sent,
  output logic               dad_req,
  output net_addr_pkg::ip_t  lla,
  output logic               addr_ok
);

  import net_addr_pkg::*;

  localparam int          TRY_W     = $clog2(`DAD_TRIES + 1);
  localparam int          TMR_W     = $clog2(`DAD_TIMEOUT_MS + 1);
  localparam logic [23:0] PRNG_SEED = 24'h6be31d;

  typedef enum logic [1:0] {
    GEN_LLA,
    DAD_REQ,
    DAD_WAIT,
    READY
  } state_t;

  state_t           state;
  iid_t             iid;
  logic [23:0]      prng;
  logic             prng_fb;
  logic [TRY_W-1:0] dad_try;
  logic [TMR_W-1:0] dad_tmr;
  logic             tmr_done;

  // Fibonacci taps for x^24 + x^23 + x^22 + x^17 + 1
  assign prng_fb  = prng[23] ^ prng[22] ^ prng[21] ^ prng[16];
  assign tmr_done = tick_ms && (dad_tmr == TMR_W'(`DAD_TIMEOUT_MS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      prng <= PRNG_SEED;
    end else begin
      prng <= {prng[22:0], prng_fb};  // Free running
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Address state machine
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= DAD_REQ;
      iid     <= form_iid(mac_addr, mac_addr[23:0]);  // MAC-derived first
      dad_try <= '0;
      dad_tmr <= '0;
    end else begin
      case (state)
        GEN_LLA: begin
          iid     <= form_iid(mac_addr, prng);  // Fresh random IID
          dad_try <= '0;
          state   <= DAD_REQ;
        end
        DAD_REQ: begin
          if (na_evt) begin
            state <= GEN_LLA;
          end else if (dad_sent) begin
            dad_try <= dad_try + 1'b1;
            dad_tmr <= '0;
            state   <= DAD_WAIT;
          end
        end
        DAD_WAIT: begin
          if (na_evt) begin
            state <= GEN_LLA;  // Someone owns this address
          end else if (tmr_done) begin
            state <= (dad_try == TRY_W'(`DAD_TRIES)) ? READY : DAD_REQ;
          end else if (tick_ms) begin
            dad_tmr <= dad_tmr + 1'b1;
          end
        end
        default: begin
          state <= READY;
        end
      endcase
    end
  end

  assign dad_req = (state == DAD_REQ);
  assign addr_ok = (state == READY);
  assign lla     = {LLA_PREFIX, iid};

endmodule

// File: logic/icmp_echo_buf.sv
`timescale 1ns/1ps
`include "icmp_nd_cfg.svh"

module icmp_echo_buf (
  input  logic                   clk,
  input  logic                   rst,
  input  byte                    pld_dat_rx,
  input  logic                   pld_val_rx,
  input  logic                   rcv,
  input  logic                   echo_evt,
  input  logic                   pld_rd,
  output byte                    pld_dat_tx,
  output logic                   pld_val_tx,
  output logic                   echo_go,
  output icmp_msg_pkg::pld_len_t echo_len,
  output icmp_msg_pkg::cks_t     echo_cks
);

  import icmp_msg_pkg::*;

  localparam int AW = $clog2(`ECHO_FIFO_DEPTH);

  byte         mem [`ECHO_FIFO_DEPTH];
  pld_len_t    wr_cnt;  // Bytes stored
  pld_len_t    rd_cnt;  // Bytes read back
  logic [31:0] sum;
  logic [16:0] fold;
  cks_t        sum_fold;
  logic        held;    // Accepted payload not yet read out
  logic        rcv_d;
  logic        accept;
  logic        wr_en;
  logic        rd_en;

  assign wr_en  = pld_val_rx && !held && (wr_cnt != pld_len_t'(`ECHO_FIFO_DEPTH));
  assign rd_en  = pld_rd && held && (rd_cnt != wr_cnt);
  assign accept = rcv_d && echo_evt && !held;

  // End-around carry, two passes are enough for 32 bits
  always_comb begin
    fold     = {1'b0, sum[15:0]} + {1'b0, sum[31:16]};
    sum_fold = fold[15:0] + {15'd0, fold[16]};
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_cnt[AW-1:0]] <= pld_dat_rx;
    end
    if (rd_en) begin
      pld_dat_tx <= mem[rd_cnt[AW-1:0]];
    end
    if (accept) begin
      echo_len <= wr_cnt;
      echo_cks <= sum_fold;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_cnt     <= '0;
      rd_cnt     <= '0;
      sum        <= '0;
      held       <= 1'b0;
      rcv_d      <= 1'b0;
      echo_go    <= 1'b0;
      pld_val_tx <= 1'b0;
    end else begin
      rcv_d      <= rcv;
      echo_go    <= accept;
      pld_val_tx <= rd_en;
      if (held) begin
        if (rd_en && (rd_cnt == wr_cnt - 1'b1)) begin  // Last byte out
          held   <= 1'b0;
          wr_cnt <= '0;
          rd_cnt <= '0;
          sum    <= '0;
        end else if (rd_en) begin
          rd_cnt <= rd_cnt + 1'b1;
        end
      end else if (rcv_d) begin
        if (accept) begin
          held <= (wr_cnt != '0);  // Empty echo has nothing to read
        end else begin
          wr_cnt <= '0;
          sum    <= '0;
        end
      end else if (wr_en) begin
        wr_cnt <= wr_cnt + 1'b1;
        // Even bytes are the high half of a word
        sum    <= sum + (wr_cnt[0] ? {24'd0, pld_dat_rx} : {16'd0, pld_dat_rx, 8'd0});
      end
    end
  end

endmodule

// File: logic/icmp_tx_arbiter.sv
`timescale 1ns/1ps
`include "icmp_nd_cfg.svh"

module icmp_tx_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  net_addr_pkg::mac_t     mac_addr,
  input  net_addr_pkg::ip_t      lla,
  input  logic                   ns_evt,
  input  icmp_msg_pkg::rx_meta_t evt_meta,
  input  logic                   dad_req,
  output logic                   dad_sent,
  input  logic                   echo_go,
  input  icmp_msg_pkg::pld_len_t echo_len,
  input  icmp_msg_pkg::cks_t     echo_cks,
  input  logic                   tx_credit,
  output logic                   tx_val,
  output icmp_msg_pkg::tx_meta_t tx_meta
);

  import net_addr_pkg::*;
  import icmp_msg_pkg::*;

  localparam int CRD_W = $clog2(`TX_CREDITS + 1);

  logic [CRD_W-1:0] credits;
  logic             na_pend;
  logic             echo_pend;
  rx_meta_t         na_req;
  rx_meta_t         echo_req;
  pld_len_t         echo_len_q;
  cks_t             echo_cks_q;
  rx_meta_t         na_src;
  rx_meta_t         echo_src;
  logic             na_take;
  logic             echo_take;
  logic             na_have;
  logic             echo_have;
  logic             issue_na;
  logic             issue_echo;
  logic             issue_dad;
  logic             tx_issue;
  tx_meta_t         na_desc;
  tx_meta_t         echo_desc;
  tx_meta_t         dad_desc;

  always_comb begin
    // Looped-back own solicitation is not answered
    na_take    = ns_evt && !na_pend && (evt_meta.src_mac != mac_addr);
    echo_take  = echo_go && !echo_pend;
    na_have    = na_pend || na_take;
    echo_have  = echo_pend || echo_take;
    na_src     = na_pend ? na_req : evt_meta;  // Slot or bypass
    echo_src   = echo_pend ? echo_req : evt_meta;
    tx_issue   = (credits != '0) && (na_have || echo_have || dad_req);
    issue_na   = tx_issue && na_have;
    issue_echo = tx_issue && !na_have && echo_have;
    issue_dad  = tx_issue && !na_have && !echo_have;
    dad_sent   = issue_dad;
  end

  //////////////////////////////////////////////////////////////////////////////
  // Descriptor assembly
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dad_desc          = '0;
    dad_desc.dst_mac  = {MAC_SOL_MCAST_PREFIX, lla[23:0]};
    dad_desc.dst_ip   = {SOL_MCAST_PREFIX, lla[23:0]};  // Source stays unspecified
    dad_desc.typ      = ICMP_NS;
    dad_desc.tar      = lla;
    dad_desc.hop      = 8'(`HOP_LIMIT_ND);

    na_desc           = '0;
    na_desc.dst_mac   = na_src.src_mac;
    na_desc.src_ip    = lla;
    na_desc.dst_ip    = na_src.src_ip;
    na_desc.typ       = ICMP_NA;
    na_desc.tar       = lla;
    na_desc.sol       = 1'b1;
    na_desc.ovr       = 1'b1;
    na_desc.hop       = 8'(`HOP_LIMIT_ND);

    echo_desc          = '0;
    echo_desc.dst_mac  = echo_src.src_mac;
    echo_desc.src_ip   = lla;
    echo_desc.dst_ip   = echo_src.src_ip;
    echo_desc.typ      = ICMP_ECHO_REPLY;
    echo_desc.hop      = 8'(`HOP_LIMIT_ND);
    echo_desc.echo_id  = echo_src.echo_id;
    echo_desc.echo_seq = echo_src.echo_seq;
    echo_desc.pld_len  = echo_pend ? echo_len_q : echo_len;
    echo_desc.pld_cks  = echo_pend ? echo_cks_q : echo_cks;
  end

  // Slot payload and outgoing descriptor
  always_ff @(posedge clk) begin
    if (na_take) begin
      na_req <= evt_meta;
    end
    if (echo_take) begin
      echo_req   <= evt_meta;
      echo_len_q <= echo_len;
      echo_cks_q <= echo_cks;
    end
    if (tx_issue) begin
      tx_meta <= issue_na ? na_desc : (issue_echo ? echo_desc : dad_desc);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credits   <= CRD_W'(`TX_CREDITS);
      na_pend   <= 1'b0;
      echo_pend <= 1'b0;
      tx_val    <= 1'b0;
    end else begin
      credits   <= credits - CRD_W'(tx_issue) + CRD_W'(tx_credit);
      na_pend   <= na_have && !issue_na;
      echo_pend <= echo_have && !issue_echo;
      tx_val    <= tx_issue;
    end
  end

endmodule

// File: logic/icmp_nd.sv
`timescale 1ns/1ps

module icmp_nd #(
  parameter net_addr_pkg::mac_t MAC_ADDR = 48'h02_00_5e_10_20_30
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   tick_ms,
  input  logic                   rcv,
  input  icmp_msg_pkg::rx_meta_t rx_meta,
  input  byte                    pld_dat_rx,
  input  logic                   pld_val_rx,
  input  logic                   pld_rd,
  input  logic                   tx_credit,
  output logic                   tx_val,
  output icmp_msg_pkg::tx_meta_t tx_meta,
  output byte                    pld_dat_tx,
  output logic                   pld_val_tx,
  output net_addr_pkg::ip_t      lla,
  output logic                   addr_ok
);

  import icmp_msg_pkg::*;

  logic     ns_evt;
  logic     na_evt;
  logic     echo_evt;
  rx_meta_t evt_meta;
  logic     dad_req;
  logic     dad_sent;
  logic     echo_go;
  pld_len_t echo_len;
  cks_t     echo_cks;

  // Receive side decode
  icmp_rx_classify u_classify (
    .clk      (clk),
    .rst      (rst),
    .rcv      (rcv),
    .rx_meta  (rx_meta),
    .lla      (lla),
    .addr_ok  (addr_ok),
    .ns_evt   (ns_evt),
    .na_evt   (na_evt),
    .echo_evt (echo_evt),
    .evt_meta (evt_meta)
  );

  icmp_addr_ctrl u_addr (
    .clk      (clk),
    .rst      (rst),
    .tick_ms  (tick_ms),
    .mac_addr (MAC_ADDR),
    .na_evt   (na_evt),
    .dad_sent (dad_sent),
    .dad_req  (dad_req),
    .lla      (lla),
    .addr_ok  (addr_ok)
  );

  icmp_echo_buf u_echo (
    .clk        (clk),
    .rst        (rst),
    .pld_dat_rx (pld_dat_rx),
    .pld_val_rx (pld_val_rx),
    .rcv        (rcv),
    .echo_evt   (echo_evt),
    .pld_rd     (pld_rd),
    .pld_dat_tx (pld_dat_tx),
    .pld_val_tx (pld_val_tx),
    .echo_go    (echo_go),
    .echo_len   (echo_len),
    .echo_cks   (echo_cks)
  );

  // Transmit selection and credits
  icmp_tx_arbiter u_arb (
    .clk       (clk),
    .rst       (rst),
    .mac_addr  (MAC_ADDR),
    .lla       (lla),
    .ns_evt    (ns_evt),
    .evt_meta  (evt_meta),
    .dad_req   (dad_req),
    .dad_sent  (dad_sent),
    .echo_go   (echo_go),
    .echo_len  (echo_len),
    .echo_cks  (echo_cks),
    .tx_credit (tx_credit),
    .tx_val    (tx_val),
    .tx_meta   (tx_meta)
  );

endmodule

// File: dv/icmp_nd_checker.sv
`timescale 1ns/1ps
`include "icmp_nd_cfg.svh"

module icmp_nd_checker #(
  parameter net_addr_pkg::mac_t MAC_ADDR = 48'h0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [127:0]           test_name,
  input  logic                   rcv,
  input  icmp_msg_pkg::rx_meta_t rx_meta,
  input  logic [7:0]             pld_dat_rx,
  input  logic                   pld_val_rx,
  input  logic [7:0]             pld_dat_tx,
  input  logic                   pld_val_tx,
  input  logic                   tx_credit,
  input  logic                   tx_val,
  input  icmp_msg_pkg::tx_meta_t tx_meta,
  input  net_addr_pkg::ip_t      lla,
  input  logic                   addr_ok,
  output int                     err_cnt,
  output int                     pending
);

  import net_addr_pkg::*;
  import icmp_msg_pkg::*;

  // EUI-64 link-local address with the U/L bit forced on
  localparam ip_t EUI_LLA = {64'hfe80_0000_0000_0000, MAC_ADDR[47:40] | 8'h02,
                             MAC_ADDR[39:24], 16'hfffe, MAC_ADDR[23:0]};

  int          errors = 0;
  int          npend  = 0;
  int          cyc    = 0;
  int          cred;
  int          dad_cnt;
  int          held_left;  // Payload bytes still to be read back
  int          rx_cnt;
  ip_t         own_ip;     // Tentative or confirmed address
  ip_t         old_ip;
  logic        own_known;
  logic        rst_d;
  logic        addr_ok_d;
  tx_meta_t    na_q[$];
  int          na_rcv_q[$];
  int          na_due_q[$];
  tx_meta_t    echo_q[$];
  logic [7:0]  rx_bytes[$];
  logic [7:0]  rd_q[$];

  assign err_cnt = errors;
  assign pending = npend;

  task report_field(input string what, input logic [127:0] exp, input logic [127:0] act);
    errors++;
    $display("[ERROR] %0s: %0s expected %0h actual %0h", test_name, what, exp, act);
  endtask

  task report_desc(input string what, input tx_meta_t exp, input tx_meta_t act);
    if (exp != act) begin
      errors++;
      $display("[ERROR] %0s: %0s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task report_msg(input string what);
    errors++;
    $display("%0s: %0s", test_name, what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Expected descriptors
  ////////////////////////////////////////////////////////////////////////////

  task check_dad(input tx_meta_t act);
    tx_meta_t exp;
    if (addr_ok) report_msg("DAD solicitation sent after the address was confirmed");
    if (!own_known) begin  // First try after a conflict
      if (act.tar[127:24] != EUI_LLA[127:24]) begin
        report_field("new tentative prefix", EUI_LLA[127:24], act.tar[127:24]);
      end
      if (act.tar == old_ip) report_msg("New tentative address repeats the conflicting one");
      own_ip    = act.tar;
      own_known = 1'b1;
    end else if (act.tar != own_ip) begin
      report_field("DAD target", own_ip, act.tar);
    end
    exp         = '0;
    exp.dst_mac = {24'h3333ff, own_ip[23:0]};
    exp.dst_ip  = {16'hff02, 64'h0, 16'h0001, 8'hff, own_ip[23:0]};
    exp.typ     = ICMP_NS;
    exp.tar     = own_ip;
    exp.hop     = 8'(`HOP_LIMIT_ND);
    report_desc("DAD descriptor", exp, act);
    dad_cnt++;
  endtask

  task check_tx(input tx_meta_t act);
    case (act.typ)
      ICMP_NS: check_dad(act);
      ICMP_NA: begin
        if (na_q.size() == 0) begin
          report_msg("NA issued without a matching NS");
        end else begin
          report_desc("NA descriptor", na_q.pop_front(), act);
          if (na_due_q[0] >= 0 && na_due_q[0] != cyc) begin
            report_field("NA issue cycle", 128'(na_due_q[0]), 128'(cyc));
          end
          void'(na_due_q.pop_front());
          void'(na_rcv_q.pop_front());
        end
      end
      ICMP_ECHO_REPLY: begin
        if (echo_q.size() == 0) begin
          report_msg("Echo reply issued without an accepted request");
        end else begin
          // NA becomes eligible one cycle after its NS is seen
          if (na_rcv_q.size() != 0 && na_rcv_q[0] <= cyc - 2) begin
            report_msg("Echo reply issued ahead of a pending NA");
          end
          report_desc("echo descriptor", echo_q.pop_front(), act);
        end
      end
      default: report_msg("Descriptor of an unknown ICMP type");
    endcase
  endtask

  task handle_rcv();
    tx_meta_t    exp;
    logic [31:0] s;
    logic [15:0] w;
    if (rx_meta.typ == ICMP_NS && addr_ok && rx_meta.tar == own_ip &&
        rx_meta.src_mac != MAC_ADDR) begin
      exp         = '0;
      exp.dst_mac = rx_meta.src_mac;
      exp.src_ip  = own_ip;
      exp.dst_ip  = rx_meta.src_ip;
      exp.typ     = ICMP_NA;
      exp.tar     = own_ip;
      exp.sol     = 1'b1;
      exp.ovr     = 1'b1;
      exp.hop     = 8'(`HOP_LIMIT_ND);
      na_due_q.push_back((cred > 0 && na_q.size() == 0 && echo_q.size() == 0) ? cyc + 2 : -1);
      na_q.push_back(exp);
      na_rcv_q.push_back(cyc);
    end
    if (rx_meta.typ == ICMP_NA && !addr_ok && own_known && rx_meta.tar == own_ip) begin
      old_ip     = own_ip;
      own_known  = 1'b0;
      dad_cnt    = 0;
    end
    if (held_left == 0) begin
      if (rx_meta.typ == ICMP_ECHO_REQUEST && addr_ok) begin
        // Big-endian 16-bit words with a zero pad byte at an odd end
        s = '0;
        for (int i = 0; i < rx_cnt; i += 2) begin
          w = {rx_bytes[i], 8'h00};
          if (i + 1 < rx_cnt) w[7:0] = rx_bytes[i + 1];
          s = s + {16'd0, w};
        end
        while (s[31:16] != 16'd0) s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
        exp          = '0;
        exp.dst_mac  = rx_meta.src_mac;
        exp.src_ip   = own_ip;
        exp.dst_ip   = rx_meta.src_ip;
        exp.typ      = ICMP_ECHO_REPLY;
        exp.hop      = 8'(`HOP_LIMIT_ND);
        exp.echo_id  = rx_meta.echo_id;
        exp.echo_seq = rx_meta.echo_seq;
        exp.pld_len  = pld_len_t'(rx_cnt);
        exp.pld_cks  = s[15:0];
        echo_q.push_back(exp);
        foreach (rx_bytes[i]) rd_q.push_back(rx_bytes[i]);
        held_left = rx_cnt;
      end
      rx_bytes.delete();
      rx_cnt = 0;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      cred       = `TX_CREDITS;
      own_ip     = EUI_LLA;
      old_ip     = '0;
      own_known  = 1'b1;
      dad_cnt    = 0;
      held_left  = 0;
      rx_cnt     = 0;
      na_q.delete();
      na_rcv_q.delete();
      na_due_q.delete();
      echo_q.delete();
      rx_bytes.delete();
      rd_q.delete();
    end else begin
      cyc++;
      if (rst_d && (tx_val || addr_ok || pld_val_tx)) report_msg("Outputs not idle after reset");
      if (tx_val) begin
        if (cred <= 0) report_msg("Descriptor issued with no free credit");
        check_tx(tx_meta);
        cred--;
      end
      if (tx_credit) cred++;
      if (pld_val_rx && held_left == 0 && rx_cnt < `ECHO_FIFO_DEPTH) begin
        rx_bytes.push_back(pld_dat_rx);
        rx_cnt++;
      end
      if (pld_val_tx) begin
        if (rd_q.size() == 0) begin
          report_msg("Payload byte read back with none expected");
        end else begin
          if (rd_q[0] != pld_dat_tx) report_field("payload byte", 128'(rd_q[0]), 128'(pld_dat_tx));
          void'(rd_q.pop_front());
          held_left--;
        end
      end
      if (rcv) handle_rcv();
      if (addr_ok && !addr_ok_d) begin  // DAD just finished
        if (!own_known || dad_cnt != `DAD_TRIES) begin
          report_field("DAD solicitations", 128'(`DAD_TRIES), 128'(dad_cnt));
        end
        if (lla != own_ip) report_field("lla", own_ip, lla);
      end
      if (!addr_ok && addr_ok_d) report_msg("addr_ok dropped without a reset");
    end
    rst_d     = rst;
    addr_ok_d = addr_ok;
    npend     = na_q.size() + echo_q.size() + rd_q.size();
  end

endmodule

// File: dv/icmp_nd_tb.sv
`timescale 1ns/1ps
`include "icmp_nd_cfg.svh"

module icmp_nd_tb;

  import net_addr_pkg::*;
  import icmp_msg_pkg::*;

  localparam mac_t        DUT_MAC  = 48'h02_00_5e_10_20_30;
  localparam mac_t        PEER_MAC = 48'h0a_1b_2c_3d_4e_5f;
  localparam ip_t         PEER_IP  = 128'hfe80_0000_0000_0000_081b_2cff_fe3d_4e5f;
  localparam int          TICK_DIV = 20;   // Clock cycles per tick_ms
  localparam int          TIMEOUT  = 3000;
  localparam logic [31:0] SEED     = 32'h0074_8d25;

  typedef enum logic [2:0] {K_DAD, K_DAD_CONFLICT, K_NS, K_ECHO, K_RELEASE} kind_t;

  typedef struct packed {
    logic [127:0] name;
    kind_t        kind;
    logic         tar_other;  // NS for an address that is not ours
    logic [7:0]   len;
    logic         hold;       // Withhold credits from here on
    logic         expect_tx;
  } row_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        tick_ms = 1'b0;
  logic        rcv;
  rx_meta_t    rx_meta;
  byte         pld_dat_rx;
  logic        pld_val_rx;
  logic        pld_rd;
  logic        tx_credit = 1'b0;
  logic        tx_val;
  tx_meta_t    tx_meta;
  byte         pld_dat_tx;
  logic        pld_val_tx;
  ip_t         lla;
  logic        addr_ok;
  logic [127:0] cur_name;
  logic        hold_credit;
  logic        ret_now;
  int          owed;
  int          tick_cnt;
  int          tx_seen = 0;
  int          tb_err  = 0;
  int          chk_err;
  int          chk_pend;
  int          pend_len;
  int          n_rows  = 0;
  row_t        rows [16];
  logic [31:0] lfsr;

  icmp_nd #(.MAC_ADDR(DUT_MAC)) u_dut (
    .clk        (clk),
    .rst        (rst),
    .tick_ms    (tick_ms),
    .rcv        (rcv),
    .rx_meta    (rx_meta),
    .pld_dat_rx (pld_dat_rx),
    .pld_val_rx (pld_val_rx),
    .pld_rd     (pld_rd),
    .tx_credit  (tx_credit),
    .tx_val     (tx_val),
    .tx_meta    (tx_meta),
    .pld_dat_tx (pld_dat_tx),
    .pld_val_tx (pld_val_tx),
    .lla        (lla),
    .addr_ok    (addr_ok)
  );

  icmp_nd_checker #(.MAC_ADDR(DUT_MAC)) u_chk (
    .clk        (clk),
    .rst        (rst),
    .test_name  (cur_name),
    .rcv        (rcv),
    .rx_meta    (rx_meta),
    .pld_dat_rx (pld_dat_rx),
    .pld_val_rx (pld_val_rx),
    .pld_dat_tx (pld_dat_tx),
    .pld_val_tx (pld_val_tx),
    .tx_credit  (tx_credit),
    .tx_val     (tx_val),
    .tx_meta    (tx_meta),
    .lla        (lla),
    .addr_ok    (addr_ok),
    .err_cnt    (chk_err),
    .pending    (chk_pend)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // Millisecond tick and downstream credit return
  always @(posedge clk) begin
    if (rst) begin
      tick_cnt  <= 0;
      tick_ms   <= 1'b0;
      owed      <= 0;
      tx_credit <= 1'b0;
    end else begin
      ret_now   = (owed != 0) && !hold_credit;
      tick_cnt  <= (tick_cnt == TICK_DIV - 1) ? 0 : tick_cnt + 1;
      tick_ms   <= (tick_cnt == TICK_DIV - 1);
      tx_credit <= ret_now;
      owed      <= owed + (tx_val ? 1 : 0) - (ret_now ? 1 : 0);
    end
    tx_seen <= tx_seen + (tx_val ? 1 : 0);
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  task add_row(input logic [127:0] name, input kind_t kind, input logic tar_other,
               input int len, input logic hold, input logic expect_tx);
    rows[n_rows] = {name, kind, tar_other, 8'(len), hold, expect_tx};
    n_rows++;
  endtask

  task do_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  endtask

  task send_pkt(input rx_meta_t m);
    @(posedge clk);
    rx_meta <= m;
    rcv     <= 1'b1;
    @(posedge clk);
    rcv     <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  task wait_tx(input int target);
    int to;
    to = 0;
    while (tx_seen < target && to < TIMEOUT) begin
      @(posedge clk);
      to++;
    end
    if (tx_seen < target) begin
      tb_err++;
      $display("%0s: timed out waiting for a transmit descriptor", cur_name);
    end
  endtask

  task wait_ready();
    int to;
    to = 0;
    while (!addr_ok && to < TIMEOUT) begin
      @(posedge clk);
      to++;
    end
    if (!addr_ok) begin
      tb_err++;
      $display("%0s: address never became valid", cur_name);
    end
  endtask

  task expect_quiet();
    int start;
    start = tx_seen;
    repeat (30) @(posedge clk);
    if (tx_seen != start) begin
      tb_err++;
      $display("%0s: descriptor issued although none was due", cur_name);
    end
  endtask

  task read_payload(input int len);
    int cnt;
    int to;
    cnt = 0;
    to  = 0;
    @(posedge clk);
    pld_rd <= 1'b1;
    while (cnt < len && to < 200) begin
      @(posedge clk);
      if (pld_val_tx) cnt++;
      to++;
    end
    pld_rd <= 1'b0;
    if (cnt < len) begin
      tb_err++;
      $display("%0s: payload read back %0d of %0d bytes", cur_name, cnt, len);
    end
  endtask

  task send_ns(input logic other);
    rx_meta_t    m;
    logic [15:0] v;
    draw_bits(16, v);
    m         = '0;
    m.src_mac = PEER_MAC;
    m.src_ip  = {PEER_IP[127:16], v};
    m.typ     = ICMP_NS;
    m.tar     = other ? (lla ^ 128'h1) : lla;
    send_pkt(m);
  endtask

  task send_echo(input int len);
    rx_meta_t    m;
    logic [15:0] v;
    for (int i = 0; i < len; i++) begin
      draw_bits(8, v);
      @(posedge clk);
      pld_dat_rx <= byte'(v[7:0]);
      pld_val_rx <= 1'b1;
    end
    @(posedge clk);
    pld_val_rx <= 1'b0;
    m         = '0;
    m.src_mac = PEER_MAC;
    m.src_ip  = PEER_IP;
    m.typ     = ICMP_ECHO_REQUEST;
    draw_bits(16, v);
    m.echo_id = v;
    draw_bits(16, v);
    m.echo_seq = v;
    send_pkt(m);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Table driver
  ////////////////////////////////////////////////////////////////////////////

  task apply_row(input row_t r);
    int       start;
    rx_meta_t m;
    @(posedge clk);
    cur_name    <= r.name;
    hold_credit <= r.hold;
    start = tx_seen;
    case (r.kind)
      K_DAD: begin
        do_reset();
        wait_ready();
      end
      K_DAD_CONFLICT: begin
        do_reset();
        wait_tx(tx_seen + 1);
        m         = '0;
        m.src_mac = PEER_MAC;
        m.src_ip  = PEER_IP;
        m.typ     = ICMP_NA;
        m.tar     = tx_meta.tar;  // Claim the tentative address
        send_pkt(m);
        wait_ready();
      end
      K_NS: begin
        send_ns(r.tar_other);
        if (r.expect_tx) wait_tx(start + 1);
        else expect_quiet();
      end
      K_ECHO: begin
        send_echo(int'(r.len));
        if (r.expect_tx) begin
          wait_tx(start + 1);
          read_payload(int'(r.len));
        end else begin
          expect_quiet();
          pend_len = int'(r.len);
        end
      end
      default: begin  // Credits back, NA then echo
        wait_tx(start + 2);
        read_payload(pend_len);
      end
    endcase
    repeat (10) @(posedge clk);
  endtask

  initial begin
    rst         = 1'b1;
    rcv         = 1'b0;
    rx_meta     = '0;
    pld_dat_rx  = 8'sd0;
    pld_val_rx  = 1'b0;
    pld_rd      = 1'b0;
    hold_credit = 1'b0;
    cur_name    = "init";
    pend_len    = 0;
    lfsr        = SEED;
    add_row("dad_plain",      K_DAD,          1'b0, 0,  1'b0, 1'b1);
    add_row("dad_conflict",   K_DAD_CONFLICT, 1'b0, 0,  1'b0, 1'b1);
    add_row("ns_own",         K_NS,           1'b0, 0,  1'b0, 1'b1);
    add_row("ns_other",       K_NS,           1'b1, 0,  1'b0, 1'b0);
    add_row("echo_13",        K_ECHO,         1'b0, 13, 1'b0, 1'b1);
    add_row("echo_64",        K_ECHO,         1'b0, 64, 1'b0, 1'b1);
    add_row("echo_1",         K_ECHO,         1'b0, 1,  1'b0, 1'b1);
    add_row("hold_echo",      K_ECHO,         1'b0, 9,  1'b1, 1'b1);
    add_row("hold_ns",        K_NS,           1'b0, 0,  1'b1, 1'b1);
    add_row("hold_echo_wait", K_ECHO,         1'b0, 20, 1'b1, 1'b0);
    add_row("hold_ns_wait",   K_NS,           1'b0, 0,  1'b1, 1'b0);
    add_row("release",        K_RELEASE,      1'b0, 0,  1'b0, 1'b1);
    for (int i = 0; i < n_rows; i++) begin
      apply_row(rows[i]);
    end
    repeat (20) @(posedge clk);
    if (chk_pend != 0) begin
      tb_err++;
      $display("%0d expected descriptors or payload bytes never appeared", chk_pend);
    end
    $display("Error counts: checker %0d, testbench %0d", chk_err, tb_err);
    if (chk_err == 0 && tb_err == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: icmp_nd.f
+incdir+logic
logic/net_addr_pkg.sv
logic/icmp_msg_pkg.sv
logic/icmp_rx_classify.sv
logic/icmp_addr_ctrl.sv
logic/icmp_echo_buf.sv
logic/icmp_tx_arbiter.sv
logic/icmp_nd.sv
dv/icmp_nd_checker.sv
dv/icmp_nd_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f icmp_nd.f --top-module icmp_nd_tb \
  -Mdir obj_dir -o icmp_nd_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/icmp_nd_sim > sim.log 2>&1 || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0
